// ==== Bender.yml ====
package:
  name: lspc

sources:
  - files:
      - hw/lspcPkg.sv
      - hw/videoSync.sv
      - hw/lspcRegs.sv
      - hw/vramPort.sv
      - hw/pixelTimer.sv
      - hw/irqCtrl.sv
      - hw/autoAnim.sv
      - hw/lspcTop.sv
  - target: simulation
    files:
      - bench/lspcBench.sv

// ==== bench/lspcBench.sv ====
module lspcBench;

	localparam int VIDEO_MODE = 0;		// NTSC
	localparam int VRAM_ADDR_BITS = 15;
	localparam int clkPeriod = 4;
	localparam int linesPerFrame = int'(lspcPkg::LINE_LAST) - int'(lspcPkg::LINE_FIRST_NTSC) + 1;
	// Clocks per NTSC frame
	localparam int frameClocks = linesPerFrame * lspcPkg::H_PIXELS * lspcPkg::PIXEL_DIV;
	localparam lspcPkg::aaSpeedT animSpeed = 8'd1;	// Step every second frame

	logic CLK_24M = 1'b0;
	logic nRESET;
	logic wrStb;
	lspcPkg::regAddrT addr;
	lspcPkg::wordT wrData;
	lspcPkg::wordT rdData;
	lspcPkg::iplT ipl;
	logic vBlank;
	logic hSync;
	logic sync;

	integer seed = 56549;

	// Reference state
	lspcPkg::wordT refMem [2 ** VRAM_ADDR_BITS];
	lspcPkg::wordT refAddr = '0;
	lspcPkg::wordT refModulo = '0;
	lspcPkg::wordT refBuf = '0;			// CPU read buffer
	lspcPkg::aaSpeedT refSpeed = '0;
	logic refDisable = 1'b0;
	lspcPkg::aaSpeedT refFrames = '0;	// Vblank starts since last step
	lspcPkg::aaCountT refAnim = '0;
	logic vbPrev = 1'b1;
	int clkCount = 0;					// Clocks since reset release

	// Pending read compares
	lspcPkg::wordT expQ [$];
	lspcPkg::wordT maskQ [$];
	lspcPkg::regAddrT regQ [$];
	time lastWrite;						// Edge that drove the last strobe

	lspcTop #(.VIDEO_MODE(VIDEO_MODE), .VRAM_ADDR_BITS(VRAM_ADDR_BITS)) dut_i (
		.CLK_24M(CLK_24M), .nRESET(nRESET), .wrStb(wrStb), .addr(addr), .wrData(wrData),
		.rdData(rdData), .ipl(ipl), .vBlank(vBlank), .hSync(hSync), .sync(sync));

	always #(clkPeriod / 2) CLK_24M = ~CLK_24M;

	// Watchdog, five frames and some slack
	initial
	begin
		#((5 * frameClocks + 20000) * clkPeriod);
		$display("Watchdog expired, the tests did not finish within five video frames");
		stopRun();
	end

	task automatic stopRun();
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped at first failure");
	endtask

	task automatic checkWord(input lspcPkg::wordT got, input lspcPkg::wordT exp, input string what);
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s read 0x%04h, expected 0x%04h", $time, what, got, exp);
			stopRun();
		end
	endtask

	task automatic checkIpl(input lspcPkg::iplT got, input lspcPkg::iplT exp, input string what);
		if (got !== exp)
		begin
			$display("ERROR at %0t: ipl %s is %0d, expected %0d", $time, what, got, exp);
			stopRun();
		end
	endtask

	task automatic checkBit(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s is %0b, expected %0b", $time, what, got, exp);
			stopRun();
		end
	endtask

	task automatic compareInterval(input int got, input int exp, input string what);
		if ((got < exp - 4) || (got > exp + 4))	// One pixel of slack either way
		begin
			$display("ERROR at %0t: %s took %0d clocks, expected %0d", $time, what, got, exp);
			stopRun();
		end
	endtask

	// CPU write effect on the reference
	function automatic void applyWrite(input lspcPkg::regAddrT a, input lspcPkg::wordT d);
		case (a)
			lspcPkg::REG_VRAMADDR:
			begin
				refAddr = d;
				refBuf = refMem[d[VRAM_ADDR_BITS-1:0]];	// Prefetch
			end
			lspcPkg::REG_VRAMDATA:
			begin
				refMem[refAddr[VRAM_ADDR_BITS-1:0]] = d;
				refAddr = refAddr + refModulo;	// Wraps at 16 bits
			end
			lspcPkg::REG_MODULO: refModulo = d;
			lspcPkg::REG_MODE:
			begin
				refSpeed = d[15:8];
				refDisable = d[3];
			end
			default: ;
		endcase
	endfunction

	// One step per refSpeed+1 vblank starts
	function automatic void stepAnim();
		if (refFrames == refSpeed)
		begin
			refFrames = '0;
			if (!refDisable)
				refAnim = refAnim + 1'b1;
		end
		else
			refFrames = refFrames + 1'b1;
	endfunction

	function automatic lspcPkg::wordT expectedRead(input lspcPkg::regAddrT a);
		case (a)
			lspcPkg::REG_MODULO, lspcPkg::REG_IRQACK: return refModulo;		// 2 and its mirror
			lspcPkg::REG_MODE, lspcPkg::REG_TIMERSTOP:
				return {9'd0, 3'b000, 1'(VIDEO_MODE), refAnim};	// Line count left at zero
			default: return refBuf;
		endcase
	endfunction

	task automatic writeReg(input lspcPkg::regAddrT a, input lspcPkg::wordT d);
		@(posedge CLK_24M);
		applyWrite(a, d);
		lastWrite = $time;
		wrStb <= 1'b1;
		addr <= a;
		wrData <= d;
		@(posedge CLK_24M);
		wrStb <= 1'b0;		// Single-cycle strobe
	endtask

	// Queue a read, compared at the falling edge
	task automatic readCheck(input lspcPkg::regAddrT a, input lspcPkg::wordT mask);
		@(posedge CLK_24M);
		addr <= a;
		expQ.push_back(expectedRead(a) & mask);
		maskQ.push_back(mask);
		regQ.push_back(a);
		@(negedge CLK_24M);
	endtask

	task automatic waitIpl(input lspcPkg::iplT level, input int limit, output time seen);
		int n;
		n = 0;
		@(negedge CLK_24M);
		while (ipl !== level)
		begin
			if (n >= limit)
			begin
				$display("Interrupt level %0d never showed up within %0d clocks", level, limit);
				stopRun();
			end
			n++;
			@(negedge CLK_24M);
		end
		seen = $time;
	endtask

	task automatic waitVblank(input logic level);
		int n;
		n = 0;
		@(negedge CLK_24M);
		while (vBlank !== level)
		begin
			if (n > frameClocks)
			begin
				$display("vBlank did not go to %0b within one frame", level);
				stopRun();
			end
			n++;
			@(negedge CLK_24M);
		end
	endtask

	always @(negedge CLK_24M)
	begin : compareProc
		lspcPkg::wordT expected;
		lspcPkg::wordT mask;
		lspcPkg::regAddrT regNum;
		if (expQ.size() != 0)
		begin
			expected = expQ.pop_front();
			mask = maskQ.pop_front();
			regNum = regQ.pop_front();
			checkWord(rdData & mask, expected, $sformatf("register %0d", regNum));
		end
		// Compare first, the DUT steps aaCount on the next edge
		if (nRESET !== 1'b1)
			vbPrev = 1'b1;
		else
		begin
			if (vBlank && !vbPrev)
				stepAnim();
			vbPrev = vBlank;
		end
	end

	// Raster position from clocks since reset, first pixel step five clocks in
	always @(negedge CLK_24M)
	begin : rasterCheck
		int pixels;
		int lineNum;
		logic expHSync;
		logic expVBlank;
		if (nRESET !== 1'b1)
			clkCount = 0;
		else
		begin
			pixels = (clkCount > 0) ? (clkCount - 1) / lspcPkg::PIXEL_DIV : 0;
			lineNum = int'(lspcPkg::LINE_FIRST_NTSC) + (pixels / lspcPkg::H_PIXELS) % linesPerFrame;
			expHSync = (pixels % lspcPkg::H_PIXELS) < 32;	// Sync pulse at line start
			expVBlank = (lineNum < int'(lspcPkg::ACTIVE_FIRST)) ||
				(lineNum > int'(lspcPkg::ACTIVE_LAST));
			checkBit(hSync, expHSync, "hSync");
			checkBit(vBlank, expVBlank, "vBlank");
			checkBit(sync, expHSync ^ expVBlank, "sync");	// Composite of both
			clkCount++;
		end
	end

	initial
	begin : stimulus
		lspcPkg::wordT burstAddr [$];
		lspcPkg::wordT nextAddr;
		lspcPkg::wordT modStep;
		lspcPkg::wordT dataWord;
		lspcPkg::wordT loadVal;
		time loadTime;
		time firstIrq;
		time secondIrq;

		nRESET = 1'b0;
		wrStb = 1'b0;
		addr = '0;
		wrData = '0;
		repeat (8) @(posedge CLK_24M);
		nRESET <= 1'b1;

		// Cold boot interrupt
		@(negedge CLK_24M);
		checkIpl(ipl, 2'd3, "after reset");
		writeReg(lspcPkg::REG_IRQACK, 16'h0004);
		repeat (2) @(posedge CLK_24M);
		@(negedge CLK_24M);
		checkIpl(ipl, 2'd0, "after level 3 acknowledge");

		// Modulo and mode readback
		modStep = 16'($random(seed));
		writeReg(lspcPkg::REG_MODULO, modStep);
		readCheck(lspcPkg::REG_MODULO, 16'hFFFF);
		writeReg(lspcPkg::REG_MODE, {animSpeed, 8'h00});
		readCheck(lspcPkg::REG_MODE, 16'h007F);		// Line count not checked

		// VRAM burst, large step so the address wraps
		modStep = 16'h8000 | 16'($random(seed));
		nextAddr = 16'($random(seed));
		writeReg(lspcPkg::REG_MODULO, modStep);
		writeReg(lspcPkg::REG_VRAMADDR, nextAddr);
		repeat (16)
		begin
			burstAddr.push_back(nextAddr);
			dataWord = 16'($random(seed));
			writeReg(lspcPkg::REG_VRAMDATA, dataWord);
			nextAddr = nextAddr + modStep;
		end
		foreach (burstAddr[i])
		begin
			writeReg(lspcPkg::REG_VRAMADDR, burstAddr[i]);
			repeat (2) @(posedge CLK_24M);	// Read buffer fill
			readCheck(lspcPkg::REG_VRAMDATA, 16'hFFFF);
		end

		// Vblank interrupt
		waitVblank(1'b0);
		waitVblank(1'b1);
		waitIpl(2'd1, 4, firstIrq);
		readCheck(lspcPkg::REG_MODE, 16'h007F);
		writeReg(lspcPkg::REG_IRQACK, 16'h0001);
		repeat (2) @(posedge CLK_24M);
		@(negedge CLK_24M);
		checkIpl(ipl, 2'd0, "after level 1 acknowledge");

		// Pixel timer, loaded at the top of the active lines
		waitVblank(1'b0);
		loadVal = 16'd200 + 16'($random(seed) & 'h1FF);
		writeReg(lspcPkg::REG_TIMERHI, 16'h0000);
		writeReg(lspcPkg::REG_MODE, {animSpeed, 8'hA0});	// Mode 5, irq still off
		writeReg(lspcPkg::REG_TIMERLO, loadVal);
		loadTime = lastWrite;
		writeReg(lspcPkg::REG_MODE, {animSpeed, 8'hB0});	// Irq on
		waitIpl(2'd2, 4 * (loadVal + 1) + 16, firstIrq);
		compareInterval((firstIrq - loadTime) / clkPeriod, 4 * (loadVal + 1), "timer load to irq");
		writeReg(lspcPkg::REG_IRQACK, 16'h0002);
		repeat (2) @(posedge CLK_24M);
		@(negedge CLK_24M);
		checkIpl(ipl, 2'd0, "after timer acknowledge");
		waitIpl(2'd2, 4 * (loadVal + 1) + 16, secondIrq);
		compareInterval((secondIrq - firstIrq) / clkPeriod, 4 * (loadVal + 1), "timer reload period");
		writeReg(lspcPkg::REG_MODE, {animSpeed, 8'h00});	// Timer quiet
		writeReg(lspcPkg::REG_IRQACK, 16'h0002);

		// Auto-animation over three frames, frozen before the last
		for (int f = 0; f < 3; f++)
		begin
			waitVblank(1'b0);
			waitVblank(1'b1);
			repeat (4) @(posedge CLK_24M);
			readCheck(lspcPkg::REG_MODE, 16'h007F);
			if (f == 1)
				writeReg(lspcPkg::REG_MODE, {animSpeed, 8'h08});	// A step was due next frame
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== hw/autoAnim.sv ====
module autoAnim (
	input logic CLK_24M,
	input logic nRESET,
	input logic vblankStart,
	input lspcPkg::aaSpeedT aaSpeed,
	input logic aaDisable,
	output lspcPkg::aaCountT aaCount
);

	lspcPkg::aaSpeedT frameCnt;	// Frames since last step

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			frameCnt <= '0;
			aaCount <= '0;
		end
		else if (vblankStart)
		begin
			// >= so a lowered speed takes effect at once
			if (frameCnt >= aaSpeed)
			begin
				frameCnt <= '0;
				if (!aaDisable)
					aaCount <= aaCount + 1'b1;	// Divider keeps running when frozen
			end
			else
				frameCnt <= frameCnt + 1'b1;
		end
	end

endmodule

// ==== hw/irqCtrl.sv ====
module irqCtrl (
	input logic CLK_24M,
	input logic nRESET,
	input logic vblankStart,
	input logic timerIrq,
	input logic ackStb,
	input logic [2:0] ackBits,
	output lspcPkg::iplT ipl
);

	logic [2:0] pending;	// Bit n is level n+1
	logic [2:0] clrMask;

	assign clrMask = ackStb ? ackBits : 3'b000;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			pending <= 3'b100;	// Cold boot raises level 3
		else
			pending <= (pending & ~clrMask) | {1'b0, timerIrq, vblankStart};	// Set wins
	end

	// Highest pending level
	always_comb
	begin
		if (pending[2])
			ipl = 2'd3;
		else if (pending[1])
			ipl = 2'd2;
		else if (pending[0])
			ipl = 2'd1;
		else
			ipl = 2'd0;
	end

	// Any event from sync or timer shows on ipl the next cycle
	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		(vblankStart || timerIrq) |=> (ipl != 2'd0));

endmodule

// ==== hw/lspcPkg.sv ====
package lspcPkg;

	// CPU side
	typedef logic [15:0] wordT;		// One CPU data word
	typedef logic [2:0] regAddrT;	// CPU address bits 3 to 1

	// Register map, word addresses
	localparam regAddrT REG_VRAMADDR = 3'd0;
	localparam regAddrT REG_VRAMDATA = 3'd1;
	localparam regAddrT REG_MODULO = 3'd2;
	localparam regAddrT REG_MODE = 3'd3;
	localparam regAddrT REG_TIMERHI = 3'd4;
	localparam regAddrT REG_TIMERLO = 3'd5;
	localparam regAddrT REG_IRQACK = 3'd6;
	localparam regAddrT REG_TIMERSTOP = 3'd7;

	// Video side
	typedef logic [8:0] lineT;		// Vertical line count
	typedef logic [8:0] pixT;		// Horizontal pixel count
	typedef logic [31:0] timerT;
	typedef logic [2:0] aaCountT;
	typedef logic [7:0] aaSpeedT;
	typedef logic [1:0] iplT;		// 0 is no interrupt, 3 is highest

	// Video timing
	localparam int H_PIXELS = 384;
	localparam int PIXEL_DIV = 4;				// 24 MHz down to pixel rate
	localparam lineT LINE_FIRST_NTSC = 9'h0F8;
	localparam lineT LINE_FIRST_PAL = 9'h0C8;	// PAL has more lines per frame
	localparam lineT LINE_LAST = 9'h1FF;
	localparam lineT ACTIVE_FIRST = 9'h110;
	localparam lineT ACTIVE_LAST = 9'h1EF;

endpackage

// ==== hw/lspcRegs.sv ====
module lspcRegs #(
	parameter int VIDEO_MODE = 0
) (
	input logic CLK_24M,
	input logic nRESET,
	input logic wrStb,
	input lspcPkg::regAddrT addr,
	input lspcPkg::wordT wrData,
	output lspcPkg::wordT rdData,
	input lspcPkg::lineT vCount,
	input lspcPkg::aaCountT aaCount,
	output logic vramWe,
	output lspcPkg::wordT vramAddr,
	output lspcPkg::wordT vramWrData,
	output logic vramRdReq,
	input lspcPkg::wordT vramRdData,
	output lspcPkg::timerT timerLoad,
	output logic [2:0] timerMode,
	output logic timerEn,
	output logic timerStop,
	output logic loadNow,
	output logic ackStb,
	output logic [2:0] ackBits,
	output lspcPkg::aaSpeedT aaSpeed,
	output logic aaDisable
);

	lspcPkg::wordT modulo;		// VRAM address increment
	lspcPkg::wordT modeWord;	// Mode register as read back

	// Payload latches
	always_ff @(posedge CLK_24M)
	begin
		if (wrStb && (addr == lspcPkg::REG_VRAMDATA))
			vramWrData <= wrData;	// Written to VRAM one cycle later
		if (wrStb && (addr == lspcPkg::REG_IRQACK))
			ackBits <= wrData[2:0];
	end

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			vramAddr <= '0;
			modulo <= '0;
			vramWe <= 1'b0;
			vramRdReq <= 1'b0;
			timerLoad <= '0;
			timerMode <= '0;
			timerEn <= 1'b0;
			timerStop <= 1'b0;
			loadNow <= 1'b0;
			ackStb <= 1'b0;
			aaSpeed <= '0;
			aaDisable <= 1'b0;
		end
		else
		begin
			// Strobes last one cycle
			vramWe <= 1'b0;
			vramRdReq <= 1'b0;
			loadNow <= 1'b0;
			ackStb <= 1'b0;

			// Advance after the delayed VRAM write, 16-bit wrap
			if (vramWe)
				vramAddr <= vramAddr + modulo;

			if (wrStb)
			begin
				case (addr)
					lspcPkg::REG_VRAMADDR:
					begin
						vramAddr <= wrData;		// Overrides a pending advance
						vramRdReq <= 1'b1;		// Prefetch into read buffer
					end
					lspcPkg::REG_VRAMDATA: vramWe <= 1'b1;
					lspcPkg::REG_MODULO: modulo <= wrData;
					lspcPkg::REG_MODE:
					begin
						aaSpeed <= wrData[15:8];
						timerMode <= wrData[7:5];
						timerEn <= wrData[4];
						aaDisable <= wrData[3];
					end
					lspcPkg::REG_TIMERHI: timerLoad[31:16] <= wrData;
					lspcPkg::REG_TIMERLO:
					begin
						timerLoad[15:0] <= wrData;
						loadNow <= timerMode[0];	// Immediate reload mode
					end
					lspcPkg::REG_IRQACK: ackStb <= 1'b1;
					lspcPkg::REG_TIMERSTOP: timerStop <= wrData[0];
				endcase
			end
		end
	end

	assign modeWord = {vCount, 3'b000, 1'(VIDEO_MODE), aaCount};

	// Decode is mirrored, only addr bits 1 and 0 matter for reads
	always_comb
	begin
		if (!addr[1])
			rdData = vramRdData;	// Addresses 0, 1, 4, 5
		else if (!addr[0])
			rdData = modulo;		// 2 and 6
		else
			rdData = modeWord;		// 3 and 7
	end

	assert property (@(posedge CLK_24M) disable iff (!nRESET) wrStb |-> !$isunknown(addr));

endmodule

// ==== hw/lspcTop.sv ====
module lspcTop #(
	parameter int VIDEO_MODE = 0,		// 0 NTSC, 1 PAL
	parameter int VRAM_ADDR_BITS = 15
) (
	input logic CLK_24M,
	input logic nRESET,
	input logic wrStb,
	input lspcPkg::regAddrT addr,
	input lspcPkg::wordT wrData,
	output lspcPkg::wordT rdData,
	output lspcPkg::iplT ipl,
	output logic vBlank,
	output logic hSync,
	output logic sync
);

	logic pixStb;
	logic vblankStart;
	lspcPkg::lineT vCount;
	logic vramWe;
	logic vramRdReq;
	lspcPkg::wordT vramAddr;
	lspcPkg::wordT vramWrData;
	lspcPkg::wordT vramRdData;
	lspcPkg::timerT timerLoad;
	logic [2:0] timerMode;
	logic timerEn;
	logic timerStop;
	logic loadNow;
	logic timerIrq;
	logic ackStb;
	logic [2:0] ackBits;
	lspcPkg::aaSpeedT aaSpeed;
	logic aaDisable;
	lspcPkg::aaCountT aaCount;

	assign sync = hSync ^ vBlank;	// Composite sync

	videoSync #(.VIDEO_MODE(VIDEO_MODE)) syncGen (
		.CLK_24M(CLK_24M), .nRESET(nRESET), .pixStb(pixStb), .hCount(),
		.vCount(vCount), .vBlank(vBlank), .vblankStart(vblankStart), .hSync(hSync));

	lspcRegs #(.VIDEO_MODE(VIDEO_MODE)) regs (
		.CLK_24M(CLK_24M), .nRESET(nRESET), .wrStb(wrStb), .addr(addr), .wrData(wrData),
		.rdData(rdData), .vCount(vCount), .aaCount(aaCount), .vramWe(vramWe),
		.vramAddr(vramAddr), .vramWrData(vramWrData), .vramRdReq(vramRdReq),
		.vramRdData(vramRdData), .timerLoad(timerLoad), .timerMode(timerMode),
		.timerEn(timerEn), .timerStop(timerStop), .loadNow(loadNow), .ackStb(ackStb),
		.ackBits(ackBits), .aaSpeed(aaSpeed), .aaDisable(aaDisable));

	vramPort #(.VRAM_ADDR_BITS(VRAM_ADDR_BITS)) vram (
		.CLK_24M(CLK_24M), .we(vramWe), .addr(vramAddr), .wrData(vramWrData),
		.rdReq(vramRdReq), .rdData(vramRdData));

	pixelTimer #(.VIDEO_MODE(VIDEO_MODE)) timer (
		.CLK_24M(CLK_24M), .nRESET(nRESET), .pixStb(pixStb), .vCount(vCount),
		.vblankStart(vblankStart), .timerLoad(timerLoad), .timerMode(timerMode),
		.timerEn(timerEn), .timerStop(timerStop), .loadNow(loadNow), .timerIrq(timerIrq));

	irqCtrl irq (
		.CLK_24M(CLK_24M), .nRESET(nRESET), .vblankStart(vblankStart), .timerIrq(timerIrq),
		.ackStb(ackStb), .ackBits(ackBits), .ipl(ipl));

	autoAnim anim (
		.CLK_24M(CLK_24M), .nRESET(nRESET), .vblankStart(vblankStart), .aaSpeed(aaSpeed),
		.aaDisable(aaDisable), .aaCount(aaCount));

endmodule

// ==== hw/pixelTimer.sv ====
module pixelTimer #(
	parameter int VIDEO_MODE = 0
) (
	input logic CLK_24M,
	input logic nRESET,
	input logic pixStb,
	input lspcPkg::lineT vCount,
	input logic vblankStart,
	input lspcPkg::timerT timerLoad,
	input logic [2:0] timerMode,
	input logic timerEn,
	input logic timerStop,
	input logic loadNow,
	output logic timerIrq
);

	lspcPkg::timerT timer;
	logic borderTop;	// Lines 0x100 to 0x10F
	logic borderBot;	// Lines 0x1F0 to 0x1FF
	logic palStop;
	logic timerRun;

	assign borderTop = (vCount[7:4] == 4'h0);
	assign borderBot = &vCount[7:4];
	assign palStop = (VIDEO_MODE != 0) && timerStop;	// Only PAL can pause in borders
	assign timerRun = vCount[8] && !(palStop && (borderTop || borderBot));

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			timer <= '0;
			timerIrq <= 1'b0;
		end
		else
		begin
			timerIrq <= 1'b0;
			if (loadNow)
				timer <= timerLoad;		// CPU load beats everything
			else if (vblankStart && timerMode[1])
				timer <= timerLoad;		// Reload at frame start
			else if (pixStb && timerRun)
			begin
				if (timer != '0)
					timer <= timer - 1'b1;
				else
				begin
					timerIrq <= timerEn;
					if (timerMode[2])
						timer <= timerLoad;	// Periodic mode
				end
			end
		end
	end

	// Strobes are PIXEL_DIV apart, so the pulse cannot stretch
	assert property (@(posedge CLK_24M) disable iff (!nRESET) timerIrq |=> !timerIrq);

endmodule

// ==== hw/videoSync.sv ====
module videoSync #(
	parameter int VIDEO_MODE = 0
) (
	input logic CLK_24M,
	input logic nRESET,
	output logic pixStb,
	output lspcPkg::pixT hCount,
	output lspcPkg::lineT vCount,
	output logic vBlank,
	output logic vblankStart,
	output logic hSync
);

	localparam int divBits = $clog2(lspcPkg::PIXEL_DIV);
	localparam lspcPkg::lineT firstLine = (VIDEO_MODE != 0) ? lspcPkg::LINE_FIRST_PAL :
		lspcPkg::LINE_FIRST_NTSC;

	logic [divBits-1:0] divCnt;		// Clock divider for pixel strobe
	logic lineEnd;
	logic vBlankQ;					// Previous vBlank, for edge detect

	assign lineEnd = pixStb && (hCount == lspcPkg::pixT'(lspcPkg::H_PIXELS - 1));

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			divCnt <= '0;
			pixStb <= 1'b0;
			hCount <= '0;
			vCount <= firstLine;	// Frame starts in top blanking
			vBlankQ <= 1'b1;		// No spurious vblankStart out of reset
		end
		else
		begin
			pixStb <= (divCnt == divBits'(lspcPkg::PIXEL_DIV - 1));
			divCnt <= divCnt + 1'b1;	// Wraps since PIXEL_DIV is a power of two
			vBlankQ <= vBlank;
			if (pixStb)
				hCount <= lineEnd ? '0 : hCount + 1'b1;
			if (lineEnd)
				vCount <= (vCount == lspcPkg::LINE_LAST) ? firstLine : vCount + 1'b1;
		end
	end

	// Blanking outside the active lines
	assign vBlank = (vCount < lspcPkg::ACTIVE_FIRST) || (vCount > lspcPkg::ACTIVE_LAST);
	assign vblankStart = vBlank && !vBlankQ;	// First clock of blanking
	assign hSync = (hCount < lspcPkg::pixT'(32));	// First 32 pixels of each line

	// Line counter stays in range and only steps by one or wraps to first line
	assert property (@(posedge CLK_24M) disable iff (!nRESET)
		(vCount >= firstLine) &&
		((vCount == $past(vCount)) || (vCount == $past(vCount) + 1'b1) || (vCount == firstLine)));

endmodule

// ==== hw/vramPort.sv ====
module vramPort #(
	parameter int VRAM_ADDR_BITS = 15
) (
	input logic CLK_24M,
	input logic we,
	input lspcPkg::wordT addr,
	input lspcPkg::wordT wrData,
	input logic rdReq,
	output lspcPkg::wordT rdData
);

	localparam int depth = 2 ** VRAM_ADDR_BITS;

	lspcPkg::wordT mem [depth];
	lspcPkg::wordT rdWord;		// RAM output register
	lspcPkg::wordT rdBuf;		// CPU read buffer
	logic rdReqQ;

	always_ff @(posedge CLK_24M)
	begin
		// Flat array, upper address bits ignored
		if (we)
			mem[addr[VRAM_ADDR_BITS-1:0]] <= wrData;
		if (rdReq)
			rdWord <= mem[addr[VRAM_ADDR_BITS-1:0]];
		rdReqQ <= rdReq;
		// Buffer only changes after an address write
		if (rdReqQ)
			rdBuf <= rdWord;
	end

	assign rdData = rdBuf;

	// Single port, a write and a prefetch cannot share a cycle
	assert property (@(posedge CLK_24M) we |-> !rdReq);

endmodule

// ==== project.f ====
hw/lspcPkg.sv
hw/videoSync.sv
hw/lspcRegs.sv
hw/vramPort.sv
hw/pixelTimer.sv
hw/irqCtrl.sv
hw/autoAnim.sv
hw/lspcTop.sv
bench/lspcBench.sv
